/* fetch_frontend.f */
fetch_pkg.sv
redirect_pkg.sv
redirect_unit.sv
fetch_pc_counter.sv
fetch_ctrl_fsm.sv
fetch_mem_port.sv
fetch_inst_buffer.sv
fetch_frontend.sv
fetch_frontend_properties.sv
tb_fetch_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the fetch frontend testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_fetch_frontend -f fetch_frontend.f
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_fetch_frontend > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0

/* tb_fetch_frontend.sv */
// testbench for the fetch frontend with memory model, redirect table, LFSR and checks

`timescale 1ns/1ps

module tb_fetch_frontend;

  localparam int NUM_ROWS       = 8;
  localparam int TIMEOUT_CYCLES = 500;
  localparam fetch_pkg::vaddr_t STEP   = fetch_pkg::vaddr_t'(fetch_pkg::FETCH_BYTES);
  localparam fetch_pkg::vaddr_t TRAP_V = 32'h0000_8104;
  localparam fetch_pkg::vaddr_t XRET_V = 32'h0000_920c;
  localparam fetch_pkg::vaddr_t BR_T   = 32'h0000_a30c;

  typedef enum logic [1:0] {K_NONE, K_COMMIT, K_BRANCH, K_BOTH} kind_t;

  // one redirect per row, target is the aligned fetch address expected next
  typedef struct packed {
    kind_t                      kind;
    redirect_pkg::flush_cause_t cause;
    fetch_pkg::vaddr_t          epc;
    fetch_pkg::vaddr_t          trap;
    fetch_pkg::vaddr_t          xret;
    fetch_pkg::vaddr_t          br;
    fetch_pkg::vaddr_t          target;
    int                         count;  // blocks to collect afterwards
    int                         hold;   // cycles with dispatch ready low
  } row_t;

  logic                       i_clk;
  logic                       i_reset_n;
  logic                       i_cmt_flush;
  redirect_pkg::flush_cause_t i_cmt_cause;
  fetch_pkg::vaddr_t          i_cmt_epc;
  fetch_pkg::vaddr_t          i_trap_vec;
  fetch_pkg::vaddr_t          i_xret_pc;
  logic                       i_br_mispredict;
  fetch_pkg::vaddr_t          i_br_target;
  logic                       i_mem_req_ready  = 1'b0;
  logic                       i_mem_resp_valid = 1'b0;
  fetch_pkg::block_t          i_mem_resp_data  = '0;
  logic                       i_disp_ready     = 1'b0;
  logic                       o_mem_req_valid;
  fetch_pkg::vaddr_t          o_mem_req_addr;
  logic                       o_disp_valid;
  fetch_pkg::vaddr_t          o_disp_pc;
  fetch_pkg::block_t          o_disp_block;

  fetch_pkg::vaddr_t addr_q [$];  // accepted requests, oldest first
  int                due_q [$];
  int                cycle_cnt    = 0;
  logic [15:0]       lfsr         = 16'd96;
  logic              hold_ready   = 1'b0;
  fetch_pkg::vaddr_t flush_target = '0;
  fetch_pkg::vaddr_t exp_pc       = fetch_pkg::RESET_PC;
  int                collected    = 0;
  int                err_count    = 0;
  int                fail_count   = 0;

  fetch_frontend UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic check_pc(input string name, input fetch_pkg::vaddr_t got,
                          input fetch_pkg::vaddr_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic check_block(input string name, input fetch_pkg::block_t got,
                             input fetch_pkg::block_t exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
      err_count++;
    end
  endtask

  // ======================================================================
  // memory model, random ready and dispatch monitor
  // ======================================================================
  always @(posedge i_clk) begin
    if (due_q.size() > 0 && due_q[0] <= cycle_cnt) begin
      i_mem_resp_valid <= 1'b1;
      i_mem_resp_data  <= {addr_q[0], ~addr_q[0]};  // address high, inverted low
      void'(addr_q.pop_front());
      void'(due_q.pop_front());
    end else begin
      i_mem_resp_valid <= 1'b0;
    end
    if (o_mem_req_valid && i_mem_req_ready) begin
      addr_q.push_back(o_mem_req_addr);
      due_q.push_back(cycle_cnt + 2);
    end
    lfsr = lfsr_step(lfsr);
    i_mem_req_ready <= lfsr[0];
    lfsr = lfsr_step(lfsr);
    i_disp_ready <= lfsr[0] & ~hold_ready;
    if (i_cmt_flush || i_br_mispredict) begin
      exp_pc <= flush_target;  // old path ends in this cycle
    end else if (o_disp_valid && i_disp_ready) begin
      check_pc("o_disp_pc", o_disp_pc, exp_pc);
      check_block("o_disp_block", o_disp_block, {exp_pc, ~exp_pc});
      exp_pc    <= exp_pc + STEP;
      collected <= collected + 1;
    end
    cycle_cnt <= cycle_cnt + 1;
  end

  // one-cycle redirect pulse
  task automatic apply_redirect(input row_t r);
    @(posedge i_clk);
    i_cmt_flush     <= (r.kind == K_COMMIT) || (r.kind == K_BOTH);
    i_br_mispredict <= (r.kind == K_BRANCH) || (r.kind == K_BOTH);
    i_cmt_cause     <= r.cause;
    i_cmt_epc       <= r.epc;
    i_trap_vec      <= r.trap;
    i_xret_pc       <= r.xret;
    i_br_target     <= r.br;
    flush_target    <= r.target;
    @(posedge i_clk);
    i_cmt_flush     <= 1'b0;
    i_br_mispredict <= 1'b0;
  endtask

  task automatic hold_dispatch(input int cycles);
    hold_ready <= 1'b1;
    repeat (cycles) @(posedge i_clk);
    if (o_mem_req_valid || !o_disp_valid) begin
      $display("requests kept going or the buffer ran dry while dispatch was held");
      fail_count++;
    end
    hold_ready <= 1'b0;
  endtask

  task automatic wait_blocks(input int n, output bit ok);
    int start;
    int waited;
    start  = collected;
    waited = 0;
    ok     = 1'b1;
    while (collected - start < n) begin
      @(posedge i_clk);
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("timeout: only %0d of %0d blocks were dispatched", collected - start, n);
        fail_count++;
        ok = 1'b0;
        break;
      end
    end
  endtask

  // ======================================================================
  // stimulus table
  // ======================================================================
  initial begin
    row_t rows [NUM_ROWS];
    bit   ok;
    i_reset_n       = 1'b0;
    i_cmt_flush     = 1'b0;
    i_cmt_cause     = redirect_pkg::SILENT_FLUSH;
    i_cmt_epc       = '0;
    i_trap_vec      = '0;
    i_xret_pc       = '0;
    i_br_mispredict = 1'b0;
    i_br_target     = '0;
    rows[0] = '{K_NONE, redirect_pkg::SILENT_FLUSH, '0, '0, '0, '0, '0, 12, 0};
    rows[1] = '{K_COMMIT, redirect_pkg::SILENT_FLUSH, 32'h2006, TRAP_V, XRET_V, BR_T,
                32'h2008, 6, 0};  // epc+4 crosses into the next block
    rows[2] = '{K_COMMIT, redirect_pkg::ANOTHER_FLUSH, 32'h3004, TRAP_V, XRET_V, BR_T,
                32'h3000, 6, 0};
    rows[3] = '{K_COMMIT, redirect_pkg::TRAP, 32'h3104, TRAP_V, XRET_V, BR_T, 32'h8100, 6, 0};
    rows[4] = '{K_COMMIT, redirect_pkg::XRET, 32'h3204, TRAP_V, XRET_V, BR_T, 32'h9208, 6, 0};
    rows[5] = '{K_BRANCH, redirect_pkg::TRAP, 32'h3304, TRAP_V, XRET_V, BR_T, 32'ha308, 6, 0};
    rows[6] = '{K_BOTH, redirect_pkg::ANOTHER_FLUSH, 32'h6004, TRAP_V, XRET_V, BR_T,
                32'h6000, 6, 0};  // commit beats branch
    rows[7] = '{K_NONE, redirect_pkg::SILENT_FLUSH, '0, '0, '0, '0, '0, 10, 40};
    repeat (8) @(posedge i_clk);
    i_reset_n <= 1'b1;
    ok = 1'b1;
    for (int i = 0; i < NUM_ROWS && ok; i++) begin
      if (rows[i].kind != K_NONE) begin
        apply_redirect(rows[i]);
      end
      if (rows[i].hold > 0) begin
        hold_dispatch(rows[i].hold);
      end
      wait_blocks(rows[i].count, ok);
    end
    $display("dispatched %0d blocks, %0d value errors, %0d other failures",
             collected, err_count, fail_count);
    if (ok && err_count == 0 && fail_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* fetch_frontend_properties.sv */
// handshake stability, in-flight limit and post-reset assertions bound into the frontend

`timescale 1ns/1ps

module fetch_frontend_properties #(
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING
) (
  input logic                                 i_clk,
  input logic                                 i_reset_n,
  input logic                                 i_flush,
  input logic                                 i_mem_req_valid,
  input fetch_pkg::vaddr_t                    i_mem_req_addr,
  input logic                                 i_mem_req_ready,
  input logic                                 i_disp_valid,
  input fetch_pkg::vaddr_t                    i_disp_pc,
  input logic                                 i_disp_ready,
  input logic [$clog2(MAX_OUTSTANDING+1)-1:0] i_outstanding
);

  // a pending request may only vanish when a flush kills it
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_mem_req_valid && !i_mem_req_ready |=>
      i_flush || (i_mem_req_valid && $stable(i_mem_req_addr)))
    else $error("memory request dropped or changed before ready");

  a_disp_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_disp_valid && !i_disp_ready && !i_flush |=> i_disp_valid && $stable(i_disp_pc))
    else $error("dispatch entry dropped or changed before ready");

  a_outstanding_max: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    int'(i_outstanding) <= MAX_OUTSTANDING)
    else $error("too many memory requests in flight");

  a_reset_quiet: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> !i_mem_req_valid && !i_disp_valid)
    else $error("valid high in the first cycle after reset");

endmodule

bind fetch_frontend fetch_frontend_properties #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_properties (
  .i_clk(i_clk), .i_reset_n(i_reset_n), .i_flush(w_flush),
  .i_mem_req_valid(o_mem_req_valid), .i_mem_req_addr(o_mem_req_addr),
  .i_mem_req_ready(i_mem_req_ready), .i_disp_valid(o_disp_valid),
  .i_disp_pc(o_disp_pc), .i_disp_ready(i_disp_ready), .i_outstanding(w_outstanding)
);

/* fetch_frontend.sv */
// fetch frontend top with redirect, pc counter, FSM, memory port and buffer

`timescale 1ns/1ps

module fetch_frontend #(
  parameter int                ADDR_W          = fetch_pkg::ADDR_W,
  parameter int                FETCH_BYTES     = fetch_pkg::FETCH_BYTES,
  parameter int                IBUF_DEPTH      = fetch_pkg::IBUF_DEPTH,
  parameter int                MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING,
  parameter logic [ADDR_W-1:0] RESET_PC        = fetch_pkg::RESET_PC
) (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  // committer
  input  logic                       i_cmt_flush,
  input  redirect_pkg::flush_cause_t i_cmt_cause,
  input  fetch_pkg::vaddr_t          i_cmt_epc,
  input  fetch_pkg::vaddr_t          i_trap_vec,
  input  fetch_pkg::vaddr_t          i_xret_pc,
  // branch resolution
  input  logic                       i_br_mispredict,
  input  fetch_pkg::vaddr_t          i_br_target,
  // instruction memory
  output logic                       o_mem_req_valid,
  output fetch_pkg::vaddr_t          o_mem_req_addr,
  input  logic                       i_mem_req_ready,
  input  logic                       i_mem_resp_valid,
  input  fetch_pkg::block_t          i_mem_resp_data,
  // dispatch
  output logic                       o_disp_valid,
  output fetch_pkg::vaddr_t          o_disp_pc,
  output fetch_pkg::block_t          o_disp_block,
  input  logic                       i_disp_ready
);

  logic                                 w_flush;
  fetch_pkg::vaddr_t                    w_target;
  logic                                 w_fetch_req;
  logic                                 w_pc_advance;
  fetch_pkg::vaddr_t                    w_fetch_pc;
  logic [$clog2(MAX_OUTSTANDING+1)-1:0] w_outstanding;
  logic                                 w_drain_busy;
  logic                                 w_resp_push;
  fetch_pkg::vaddr_t                    w_push_pc;
  fetch_pkg::block_t                    w_push_block;
  logic [$clog2(IBUF_DEPTH+1)-1:0]      w_free_slots;

  redirect_unit #(.ADDR_W(ADDR_W), .FETCH_BYTES(FETCH_BYTES)) u_redirect (
    .i_cmt_flush(i_cmt_flush), .i_cmt_cause(i_cmt_cause), .i_cmt_epc(i_cmt_epc),
    .i_trap_vec(i_trap_vec), .i_xret_pc(i_xret_pc),
    .i_br_mispredict(i_br_mispredict), .i_br_target(i_br_target),
    .o_flush(w_flush), .o_src(), .o_target(w_target)
  );

  fetch_pc_counter #(.ADDR_W(ADDR_W), .FETCH_BYTES(FETCH_BYTES), .RESET_PC(RESET_PC)) u_pc (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_flush(w_flush), .i_target(w_target),
    .i_advance(w_pc_advance), .o_pc(w_fetch_pc)
  );

  fetch_ctrl_fsm #(.IBUF_DEPTH(IBUF_DEPTH), .MAX_OUTSTANDING(MAX_OUTSTANDING)) u_fsm (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_flush(w_flush),
    .i_mem_req_ready(i_mem_req_ready), .i_free_slots(w_free_slots),
    .i_outstanding(w_outstanding), .i_drain_busy(w_drain_busy),
    .o_fetch_req(w_fetch_req), .o_pc_advance(w_pc_advance), .o_state()
  );

  fetch_mem_port #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_mem_port (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_flush(w_flush),
    .i_req_valid(w_fetch_req), .i_req_addr(w_fetch_pc), .i_mem_req_ready(i_mem_req_ready),
    .o_mem_req_valid(o_mem_req_valid), .o_mem_req_addr(o_mem_req_addr),
    .i_mem_resp_valid(i_mem_resp_valid), .i_mem_resp_data(i_mem_resp_data),
    .o_outstanding(w_outstanding), .o_drain_busy(w_drain_busy),
    .o_push(w_resp_push), .o_push_pc(w_push_pc), .o_push_block(w_push_block)
  );

  fetch_inst_buffer #(.IBUF_DEPTH(IBUF_DEPTH)) u_ibuf (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_flush(w_flush),
    .i_push(w_resp_push), .i_push_pc(w_push_pc), .i_push_block(w_push_block),
    .o_free_slots(w_free_slots), .o_disp_valid(o_disp_valid),
    .o_disp_pc(o_disp_pc), .o_disp_block(o_disp_block), .i_disp_ready(i_disp_ready)
  );

endmodule

/* fetch_inst_buffer.sv */
// circular FIFO of fetched blocks toward dispatch with free count and flush

`timescale 1ns/1ps

module fetch_inst_buffer #(
  parameter int IBUF_DEPTH = fetch_pkg::IBUF_DEPTH
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  logic                            i_flush,
  input  logic                            i_push,
  input  fetch_pkg::vaddr_t               i_push_pc,
  input  fetch_pkg::block_t               i_push_block,
  output logic [$clog2(IBUF_DEPTH+1)-1:0] o_free_slots,
  output logic                            o_disp_valid,
  output fetch_pkg::vaddr_t               o_disp_pc,
  output fetch_pkg::block_t               o_disp_block,
  input  logic                            i_disp_ready
);

  localparam int CNT_W = $clog2(IBUF_DEPTH+1);
  localparam int PTR_W = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;

  logic              w_pop;
  logic [CNT_W-1:0]  r_count;
  logic [PTR_W-1:0]  r_wr_ptr;
  logic [PTR_W-1:0]  r_rd_ptr;
  fetch_pkg::vaddr_t r_pc_mem    [IBUF_DEPTH];
  fetch_pkg::block_t r_block_mem [IBUF_DEPTH];

  assign w_pop = o_disp_valid & i_disp_ready;

  // ======================================================================
  // pointers and occupancy
  // ======================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count  <= '0;
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else if (i_flush) begin
      r_count  <= '0;  // drop everything from the old path
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      r_count <= r_count + CNT_W'(i_push) - CNT_W'(w_pop);
      if (i_push) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(IBUF_DEPTH-1)) ? '0 : r_wr_ptr + PTR_W'(1);
      end
      if (w_pop) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(IBUF_DEPTH-1)) ? '0 : r_rd_ptr + PTR_W'(1);
      end
    end
  end

  // entry storage
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_pc_mem[r_wr_ptr]    <= i_push_pc;
      r_block_mem[r_wr_ptr] <= i_push_block;
    end
  end

  // ======================================================================
  // dispatch side
  // ======================================================================
  assign o_disp_valid = (r_count != '0);
  assign o_disp_pc    = r_pc_mem[r_rd_ptr];
  assign o_disp_block = r_block_mem[r_rd_ptr];
  assign o_free_slots = CNT_W'(IBUF_DEPTH) - r_count;  // FSM sizes requests by this

endmodule

/* fetch_mem_port.sv */
// memory request and response port with in-flight count and stale drop

`timescale 1ns/1ps

module fetch_mem_port #(
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic                                 i_flush,
  input  logic                                 i_req_valid,
  input  fetch_pkg::vaddr_t                    i_req_addr,
  input  logic                                 i_mem_req_ready,
  output logic                                 o_mem_req_valid,
  output fetch_pkg::vaddr_t                    o_mem_req_addr,
  input  logic                                 i_mem_resp_valid,
  input  fetch_pkg::block_t                    i_mem_resp_data,
  output logic [$clog2(MAX_OUTSTANDING+1)-1:0] o_outstanding,
  output logic                                 o_drain_busy,
  output logic                                 o_push,
  output fetch_pkg::vaddr_t                    o_push_pc,
  output fetch_pkg::block_t                    o_push_block
);

  localparam int OUT_W = $clog2(MAX_OUTSTANDING+1);
  localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;

  logic              w_fire;
  logic [OUT_W-1:0]  w_outstanding_next;
  logic [OUT_W-1:0]  r_outstanding;
  logic [OUT_W-1:0]  r_discard;    // stale responses still to drop
  logic [PTR_W-1:0]  r_wr_ptr;
  logic [PTR_W-1:0]  r_rd_ptr;
  fetch_pkg::vaddr_t r_addr_q [MAX_OUTSTANDING];

  assign o_mem_req_valid = i_req_valid;
  assign o_mem_req_addr  = i_req_addr;
  assign w_fire          = i_req_valid & i_mem_req_ready;

  assign w_outstanding_next = r_outstanding + OUT_W'(w_fire) - OUT_W'(i_mem_resp_valid);

  // ======================================================================
  // in-flight and discard counters
  // ======================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_outstanding <= '0;
      r_discard     <= '0;
      r_wr_ptr      <= '0;
      r_rd_ptr      <= '0;
    end else begin
      r_outstanding <= w_outstanding_next;
      if (i_flush) begin
        r_discard <= w_outstanding_next;       // all that is left belongs to the old path
      end else if (i_mem_resp_valid && (r_discard != '0)) begin
        r_discard <= r_discard - OUT_W'(1);
      end
      if (w_fire) begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(MAX_OUTSTANDING-1)) ? '0 : r_wr_ptr + PTR_W'(1);
      end
      if (i_mem_resp_valid) begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(MAX_OUTSTANDING-1)) ? '0 : r_rd_ptr + PTR_W'(1);
      end
    end
  end

  // request address queue, responses come back in order
  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      r_addr_q[r_wr_ptr] <= i_req_addr;
    end
  end

  assign o_outstanding = r_outstanding;
  assign o_drain_busy  = (r_discard != '0);
  assign o_push        = i_mem_resp_valid & (r_discard == '0) & ~i_flush;
  assign o_push_pc     = r_addr_q[r_rd_ptr];
  assign o_push_block  = i_mem_resp_data;

endmodule

/* fetch_ctrl_fsm.sv */
// fetch state machine for request issue, buffer stalls and flush drain

`timescale 1ns/1ps

module fetch_ctrl_fsm #(
  parameter int IBUF_DEPTH      = fetch_pkg::IBUF_DEPTH,
  parameter int MAX_OUTSTANDING = fetch_pkg::MAX_OUTSTANDING
) (
  input  logic                                 i_clk,
  input  logic                                 i_reset_n,
  input  logic                                 i_flush,
  input  logic                                 i_mem_req_ready,
  input  logic [$clog2(IBUF_DEPTH+1)-1:0]      i_free_slots,
  input  logic [$clog2(MAX_OUTSTANDING+1)-1:0] i_outstanding,
  input  logic                                 i_drain_busy,
  output logic                                 o_fetch_req,
  output logic                                 o_pc_advance,
  output fetch_pkg::if_state_t                 o_state
);

  fetch_pkg::if_state_t r_state;
  fetch_pkg::if_state_t w_state_next;
  logic                 w_room;
  logic                 w_issue_state;

  // ======================================================================
  // issue condition
  // ======================================================================
  // every request in flight must find a free buffer slot on return
  assign w_room = (int'(i_free_slots) > int'(i_outstanding)) &&
                  (int'(i_outstanding) < MAX_OUTSTANDING);

  // once the drain is over the first target request can go out at once
  assign w_issue_state = (r_state == fetch_pkg::FETCH_REQ) ||
                         ((r_state == fetch_pkg::WAIT_FLUSH_FREE) && !i_drain_busy);

  assign o_fetch_req  = w_issue_state & w_room & ~i_flush;  // old path dies on flush
  assign o_pc_advance = o_fetch_req & i_mem_req_ready;

  // ======================================================================
  // next state
  // ======================================================================
  always_comb begin
    w_state_next = r_state;
    case (r_state)
      fetch_pkg::INIT: begin
        w_state_next = fetch_pkg::FETCH_REQ;
      end
      fetch_pkg::FETCH_REQ: begin
        if (!w_room) begin
          w_state_next = fetch_pkg::WAIT_IBUF_FREE;
        end
      end
      fetch_pkg::WAIT_IBUF_FREE: begin
        if (w_room) begin
          w_state_next = fetch_pkg::FETCH_REQ;  // dispatch freed a slot
        end
      end
      fetch_pkg::WAIT_FLUSH_FREE: begin
        if (!i_drain_busy) begin
          w_state_next = w_room ? fetch_pkg::FETCH_REQ : fetch_pkg::WAIT_IBUF_FREE;
        end
      end
      default: begin
        w_state_next = fetch_pkg::INIT;
      end
    endcase
    // any redirect restarts the drain wait
    if (i_flush) begin
      w_state_next = fetch_pkg::WAIT_FLUSH_FREE;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= fetch_pkg::INIT;
    end else begin
      r_state <= w_state_next;
    end
  end

  assign o_state = r_state;

endmodule

/* fetch_pc_counter.sv */
// fetch block address register with block step and redirect load

`timescale 1ns/1ps

module fetch_pc_counter #(
  parameter int                ADDR_W      = fetch_pkg::ADDR_W,
  parameter int                FETCH_BYTES = fetch_pkg::FETCH_BYTES,
  parameter logic [ADDR_W-1:0] RESET_PC    = fetch_pkg::RESET_PC
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_flush,
  input  fetch_pkg::vaddr_t i_target,  // already aligned
  input  logic              i_advance,
  output fetch_pkg::vaddr_t o_pc
);

  localparam fetch_pkg::vaddr_t BLOCK_STEP = fetch_pkg::vaddr_t'(FETCH_BYTES);

  fetch_pkg::vaddr_t r_pc;

  // ======================================================================
  // block address
  // ======================================================================
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pc <= RESET_PC;
    end else if (i_flush) begin
      r_pc <= i_target;               // redirect beats a normal step
    end else if (i_advance) begin
      r_pc <= r_pc + BLOCK_STEP;      // request accepted by memory
    end
  end

  assign o_pc = r_pc;

endmodule

/* redirect_unit.sv */
// redirect target selection from committer flush and branch mispredict

`timescale 1ns/1ps

module redirect_unit #(
  parameter int ADDR_W      = fetch_pkg::ADDR_W,
  parameter int FETCH_BYTES = fetch_pkg::FETCH_BYTES
) (
  input  logic                       i_cmt_flush,
  input  redirect_pkg::flush_cause_t i_cmt_cause,
  input  fetch_pkg::vaddr_t          i_cmt_epc,
  input  fetch_pkg::vaddr_t          i_trap_vec,
  input  fetch_pkg::vaddr_t          i_xret_pc,
  input  logic                       i_br_mispredict,
  input  fetch_pkg::vaddr_t          i_br_target,
  output logic                       o_flush,
  output redirect_pkg::redirect_src_t o_src,
  output fetch_pkg::vaddr_t          o_target
);

  localparam int OFF_W = $clog2(FETCH_BYTES);
  localparam logic [ADDR_W-1:0] ALIGN_MASK = {{(ADDR_W-OFF_W){1'b1}}, {OFF_W{1'b0}}};

  fetch_pkg::vaddr_t w_target_raw;

  // commit is older than any branch in flight, so it wins
  always_comb begin
    o_src        = redirect_pkg::SRC_NONE;
    w_target_raw = i_br_target;
    if (i_cmt_flush) begin
      o_src = redirect_pkg::SRC_COMMIT;
      case (i_cmt_cause)
        redirect_pkg::SILENT_FLUSH:  w_target_raw = i_cmt_epc + fetch_pkg::vaddr_t'(4);
        redirect_pkg::ANOTHER_FLUSH: w_target_raw = i_cmt_epc;
        redirect_pkg::TRAP:          w_target_raw = i_trap_vec;
        redirect_pkg::XRET:          w_target_raw = i_xret_pc;
        default:                     w_target_raw = i_cmt_epc;
      endcase
    end else if (i_br_mispredict) begin
      o_src = redirect_pkg::SRC_BRANCH;
    end
  end

  assign o_flush  = (o_src != redirect_pkg::SRC_NONE);
  assign o_target = w_target_raw & ALIGN_MASK;  // block address of target

endmodule

/* redirect_pkg.sv */
// committer flush causes and redirect source encodings

package redirect_pkg;

  // ======================================================================
  // committer flush cause
  // ======================================================================
  typedef enum logic [1:0] {
    SILENT_FLUSH  = 2'd0,  // resume at epc+4
    ANOTHER_FLUSH = 2'd1,  // refetch at epc
    TRAP          = 2'd2,  // jump to trap vector
    XRET          = 2'd3   // back to saved exception pc
  } flush_cause_t;

  // ======================================================================
  // which side won the redirect
  // ======================================================================
  typedef enum logic [1:0] {
    SRC_NONE   = 2'd0,
    SRC_COMMIT = 2'd1,
    SRC_BRANCH = 2'd2
  } redirect_src_t;

endpackage

/* fetch_pkg.sv */
// fetch block sizes, buffer limits, fetch state enum, address and block types

package fetch_pkg;

  // ======================================================================
  // sizes
  // ======================================================================
  parameter int ADDR_W          = 32;
  parameter int FETCH_BYTES     = 8;                // one aligned fetch block
  parameter int BLOCK_W         = 8 * FETCH_BYTES;
  parameter int IBUF_DEPTH      = 4;
  parameter int MAX_OUTSTANDING = 2;                // memory requests in flight

  parameter logic [ADDR_W-1:0] RESET_PC = 32'h0000_1000;

  // ======================================================================
  // types
  // ======================================================================
  typedef logic [ADDR_W-1:0]  vaddr_t;
  typedef logic [BLOCK_W-1:0] block_t;

  // fetch sequencing states
  typedef enum logic [1:0] {
    INIT            = 2'd0,
    FETCH_REQ       = 2'd1,
    WAIT_IBUF_FREE  = 2'd2,  // no room for another response
    WAIT_FLUSH_FREE = 2'd3   // stale responses still in flight
  } if_state_t;

endpackage
